/* Makefile */
TOP := clint_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -qx "Everything OK" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* build.f */
verilog/clint_pkg.sv
verilog/clint_tick.sv
verilog/clint_soft.sv
verilog/clint_timer.sv
verilog/clint_response.sv
verilog/clint_top.sv
test/clint_tb.sv

/* test/clint_tb.sv */
`timescale 1ns/1ps

module clint_tb;

  typedef enum logic [1:0] {
    op_write,
    op_read,
    op_mtip,    // wait for an mtip level
    op_elapse   // let mtime run, then check it
  } op_t;

  typedef struct packed {
    op_t                    op;
    clint_pkg::clint_addr_t addr;
    clint_pkg::clint_data_t wdata;
    logic                   random;      // write $urandom data instead of wdata
    clint_pkg::clint_data_t expected;
    logic                   from_model;  // expected read value comes from the register model
    logic                   error;
  } step_t;

  localparam int reply_timeout = 4;
  localparam int mtip_timeout  = 4;
  localparam int elapse_cycles = 10 * clint_pkg::tick_period;

  localparam clint_pkg::clint_addr_t msip0    = clint_pkg::msip_base;
  localparam clint_pkg::clint_addr_t msip1    = clint_pkg::msip_base + 32'd4;
  localparam clint_pkg::clint_addr_t cmp0     = clint_pkg::mtimecmp_base;
  localparam clint_pkg::clint_addr_t cmp1     = clint_pkg::mtimecmp_base + 32'd8;
  localparam clint_pkg::clint_addr_t unmapped = 32'h0000_2000;

  logic                    clock;
  logic                    reset;
  clint_pkg::mem_in_t      request;
  clint_pkg::mem_out_t     reply;
  clint_pkg::clint_data_t  mtime;
  clint_pkg::clint_harts_t msip;
  clint_pkg::clint_harts_t mtip;

  step_t steps[$];

  // register model, kept from the writes the table makes
  clint_pkg::clint_harts_t msip_model;
  clint_pkg::clint_data_t  cmp_model [clint_pkg::hart_count];
  clint_pkg::clint_data_t  mtime_written;

  clint_top i_dut (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .reply   (reply),
    .mtime   (mtime),
    .msip    (msip),
    .mtip    (mtip)
  );

  always #5 clock = ~clock;

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input clint_pkg::clint_data_t actual,
                            input clint_pkg::clint_data_t expected,
                            input clint_pkg::clint_data_t slack,
                            input string what);
    if ($isunknown(actual) || actual - expected > slack) begin  // unsigned, so actual must lie in expected..+slack
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h +%0d",
                         $time, what, actual, expected, slack));
    end
  endtask

  task automatic check_harts(input clint_pkg::clint_harts_t actual,
                             input clint_pkg::clint_harts_t expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_error(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s error got %b expected %b",
                         $time, what, actual, expected));
    end
  endtask

  task automatic add_step(input op_t op, input clint_pkg::clint_addr_t addr,
                          input clint_pkg::clint_data_t wdata, input logic random,
                          input clint_pkg::clint_data_t expected, input logic from_model,
                          input logic error);
    steps.push_back('{op, addr, wdata, random, expected, from_model, error});
  endtask

  // one-cycle request, then wait for ready
  task automatic bus_access(input clint_pkg::clint_addr_t addr,
                            input clint_pkg::clint_data_t wdata, input logic write,
                            output clint_pkg::clint_data_t rdata, output logic error);
    int cycles;
    request.valid = 1'b1;
    request.addr  = addr;
    request.wdata = wdata;
    request.wstrb = write ? '1 : '0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      request = '0;
    end while (!reply.ready && cycles < reply_timeout);
    if (!reply.ready) begin
      fail_run($sformatf("no reply from the bus for address %h", addr));
    end
    if (cycles != 1) begin
      fail_run($sformatf("MISMATCH at %0t: ready after %0d cycles expected 1", $time, cycles));
    end
    rdata = reply.rdata;
    error = reply.error;
  endtask

  task automatic wait_for_mtip(input clint_pkg::clint_harts_t expected, input int step_no);
    int cycles;
    cycles = 0;
    while (mtip !== expected && cycles < mtip_timeout) begin
      @(negedge clock);
      cycles++;
    end
    check_harts(mtip, expected, $sformatf("step %0d mtip level", step_no));
  endtask

  task automatic model_write(input clint_pkg::clint_addr_t addr,
                             input clint_pkg::clint_data_t wdata);
    if (addr == clint_pkg::mtime_addr) begin
      mtime_written = wdata;
    end else if (addr >= clint_pkg::mtimecmp_base) begin
      cmp_model[int'((addr - clint_pkg::mtimecmp_base) / 8)] = wdata;
    end else begin
      msip_model[int'((addr - clint_pkg::msip_base) / 4)] = wdata[0];
    end
  endtask

  function automatic clint_pkg::clint_data_t model_read(input clint_pkg::clint_addr_t addr);
    if (addr == clint_pkg::mtime_addr) begin
      return mtime_written;
    end else if (addr >= clint_pkg::mtimecmp_base) begin
      return cmp_model[int'((addr - clint_pkg::mtimecmp_base) / 8)];
    end
    return {63'd0, msip_model[int'((addr - clint_pkg::msip_base) / 4)]};
  endfunction

  initial begin
    step_t                  step;
    clint_pkg::clint_data_t wdata;
    clint_pkg::clint_data_t rdata;
    clint_pkg::clint_data_t expected;
    clint_pkg::clint_data_t slack;
    logic                   error;

    void'($urandom(30211));
    clock         = 1'b0;
    reset         = 1'b0;
    request       = '0;
    msip_model    = '0;
    cmp_model     = '{default: '0};
    mtime_written = '0;

    add_step(op_mtip,   '0,         '0,  1'b0, 64'd3, 1'b0, 1'b0);  // mtime >= 0 after reset
    // fixed patterns set and clear each msip bit
    add_step(op_write,  msip0,      64'h1, 1'b0, '0, 1'b0, 1'b0);
    add_step(op_write,  msip1,      64'hFFFF_FFFF_FFFF_FFFE, 1'b0, '0, 1'b0, 1'b0);
    add_step(op_read,   msip0,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  msip0,      64'hFFFF_FFFF_FFFF_FFFE, 1'b0, '0, 1'b0, 1'b0);
    add_step(op_write,  msip1,      64'h1, 1'b0, '0, 1'b0, 1'b0);
    add_step(op_read,   msip1,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  msip0,      '0,  1'b1, '0,    1'b0, 1'b0);
    add_step(op_read,   msip0,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  msip1,      '0,  1'b1, '0,    1'b0, 1'b0);
    add_step(op_read,   msip1,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_read,   msip0,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  cmp0,       '0,  1'b1, '0,    1'b0, 1'b0);
    add_step(op_write,  cmp1,       '0,  1'b1, '0,    1'b0, 1'b0);
    add_step(op_read,   cmp0,       '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_read,   cmp1,       '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  cmp0,       '1,  1'b0, '0,    1'b0, 1'b0);
    add_step(op_write,  cmp1,       '0,  1'b0, '0,    1'b0, 1'b0);
    add_step(op_mtip,   '0,         '0,  1'b0, 64'd2, 1'b0, 1'b0);
    add_step(op_write,  cmp0,       '0,  1'b0, '0,    1'b0, 1'b0);
    add_step(op_mtip,   '0,         '0,  1'b0, 64'd3, 1'b0, 1'b0);
    add_step(op_write,  cmp1,       '1,  1'b0, '0,    1'b0, 1'b0);
    add_step(op_mtip,   '0,         '0,  1'b0, 64'd1, 1'b0, 1'b0);
    add_step(op_read,   unmapped,   '0,  1'b0, '0,    1'b0, 1'b1);
    add_step(op_write,  unmapped,   '0,  1'b1, '0,    1'b0, 1'b1);
    add_step(op_read,   msip0,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_read,   msip1,      '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_read,   cmp0,       '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_read,   cmp1,       '0,  1'b0, '0,    1'b1, 1'b0);
    add_step(op_write,  clint_pkg::mtime_addr, '0, 1'b1, '0, 1'b0, 1'b0);
    add_step(op_read,   clint_pkg::mtime_addr, '0, 1'b0, '0, 1'b1, 1'b0);
    add_step(op_elapse, '0,         '0,  1'b0, '0,    1'b0, 1'b0);

    repeat (8) @(negedge clock);
    reset = 1'b1;

    check_harts(msip, '0, "msip after reset");
    check_data(mtime, '0, clint_pkg::clint_data_t'(elapse_cycles - 1), "mtime after reset");

    for (int i = 0; i < steps.size(); i++) begin
      step = steps[i];
      case (step.op)
        op_write: begin
          wdata = step.random ? {$urandom, $urandom} : step.wdata;
          bus_access(step.addr, wdata, 1'b1, rdata, error);
          if (!step.error) begin
            model_write(step.addr, wdata);
          end
          check_error(error, step.error, $sformatf("step %0d write", i));
          check_data(rdata, '0, '0, $sformatf("step %0d write reply data", i));
          check_harts(msip, msip_model, $sformatf("step %0d msip output", i));
        end
        op_read: begin
          bus_access(step.addr, '0, 1'b0, rdata, error);
          expected = step.from_model ? model_read(step.addr) : step.expected;
          slack    = (step.addr == clint_pkg::mtime_addr) ? 64'd1 : 64'd0;  // a tick may land
          check_error(error, step.error, $sformatf("step %0d read", i));
          check_data(rdata, expected, slack, $sformatf("step %0d read data", i));
          check_harts(msip, msip_model, $sformatf("step %0d msip output", i));
        end
        op_mtip: begin
          wait_for_mtip(clint_pkg::clint_harts_t'(step.expected), i);
        end
        default: begin
          for (int c = 0; c < elapse_cycles; c++) begin
            @(negedge clock);
            check_error(reply.ready, 1'b0, $sformatf("step %0d idle ready", i));  // no request
          end
          // ten ticks plus or minus one since the write
          check_data(mtime, mtime_written + 64'd9, 64'd2, $sformatf("step %0d mtime", i));
        end
      endcase
    end

    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog/clint_pkg.sv */
package clint_pkg;

  // system size and timer rate
  localparam int hart_count  = 2;
  localparam int tick_period = 5;  // clock cycles per mtime step

  localparam int hart_width = (hart_count > 1) ? $clog2(hart_count) : 1;
  localparam int tick_width = (tick_period > 1) ? $clog2(tick_period) : 1;

  typedef logic [31:0]           clint_addr_t;
  typedef logic [63:0]           clint_data_t;
  typedef logic [7:0]            clint_strb_t;
  typedef logic [hart_count-1:0] clint_harts_t;

  // address map
  localparam clint_addr_t msip_base     = 32'h0000_0000;
  localparam clint_addr_t msip_span     = clint_addr_t'(4 * hart_count);  // one word per hart
  localparam clint_addr_t mtimecmp_base = 32'h0000_4000;
  localparam clint_addr_t mtimecmp_span = clint_addr_t'(8 * hart_count);
  localparam clint_addr_t mtime_addr    = 32'h0000_BFF8;

  // last count value of the prescaler
  localparam logic [tick_width-1:0] tick_last = tick_width'(tick_period - 1);

  // bus request, any set strobe bit makes it a write
  typedef struct packed {
    logic        valid;
    clint_addr_t addr;
    clint_data_t wdata;
    clint_strb_t wstrb;
  } mem_in_t;

  // bus reply
  typedef struct packed {
    logic        ready;
    clint_data_t rdata;
    logic        error;
  } mem_out_t;

  // registered reply of one register block
  typedef struct packed {
    logic        hit;
    clint_data_t rdata;
  } block_resp_t;

endpackage

/* verilog/clint_response.sv */
`timescale 1ns/1ps

module clint_response (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   valid,
  input  clint_pkg::block_resp_t soft_reply,
  input  clint_pkg::block_resp_t timer_reply,
  output clint_pkg::mem_out_t    reply
);

  logic valid_q;  // request seen last cycle
  logic any_hit;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  assign any_hit = soft_reply.hit | timer_reply.hit;

  always_comb begin
    reply.ready = valid_q;
    reply.error = valid_q & ~any_hit;  // nobody decoded the address
    if (soft_reply.hit) begin
      reply.rdata = soft_reply.rdata;
    end else if (timer_reply.hit) begin
      reply.rdata = timer_reply.rdata;
    end else begin
      reply.rdata = '0;
    end
  end

  // the address windows of the blocks must not overlap
  single_block_hit: assert property (
    @(posedge clock) disable iff (!reset) !(soft_reply.hit && timer_reply.hit)
  ) else $error("software and timer blocks claimed the same request");

endmodule

/* verilog/clint_soft.sv */
`timescale 1ns/1ps

module clint_soft (
  input  logic                    clock,
  input  logic                    reset,
  input  clint_pkg::mem_in_t      request,
  output clint_pkg::block_resp_t  reply,
  output clint_pkg::clint_harts_t msip
);

  clint_pkg::clint_addr_t           soft_offset;
  logic [clint_pkg::hart_width-1:0] soft_index;
  logic                             soft_sel;
  logic                             is_write;

  assign is_write    = |request.wstrb;
  assign soft_offset = request.addr - clint_pkg::msip_base;
  assign soft_sel    = (soft_offset < clint_pkg::msip_span) && (soft_offset[1:0] == 2'b00);
  assign soft_index  = soft_offset[2 +: clint_pkg::hart_width];  // one word per hart

  // only bit 0 of the word is stored
  always_ff @(posedge clock) begin
    if (!reset) begin
      msip <= '0;
    end else if (request.valid && soft_sel && is_write) begin
      msip[soft_index] <= request.wdata[0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      reply <= '0;
    end else begin
      reply <= '0;
      if (request.valid && soft_sel) begin
        reply.hit <= 1'b1;
        if (!is_write) begin
          reply.rdata <= clint_pkg::clint_data_t'(msip[soft_index]);
        end
      end
    end
  end

  soft_hit_follows_request: assert property (
    @(posedge clock) disable iff (!reset) reply.hit |-> $past(request.valid)
  ) else $error("software block reply without a request");

endmodule

/* verilog/clint_tick.sv */
`timescale 1ns/1ps

module clint_tick (
  input  logic clock,
  input  logic reset,
  output logic tick
);

  logic [clint_pkg::tick_width-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == clint_pkg::tick_last) begin
      count <= '0;
      tick  <= 1'b1;  // one pulse per wrap
    end else begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

  // mtime must step at most once per period
  tick_single_cycle: assert property (
    @(posedge clock) disable iff (!reset) tick |=> !tick
  ) else $error("tick held high for two cycles");

endmodule

/* verilog/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
  input  logic                    clock,
  input  logic                    reset,
  input  clint_pkg::mem_in_t      request,
  output clint_pkg::block_resp_t  reply,
  output clint_pkg::clint_data_t  mtime,
  output clint_pkg::clint_harts_t mtip
);

  clint_pkg::clint_data_t mtimecmp [clint_pkg::hart_count];

  logic tick;

  clint_pkg::clint_addr_t              cmp_offset;
  logic [clint_pkg::hart_width-1:0]    cmp_index;
  logic                                cmp_sel;
  logic                                time_sel;
  logic                                is_write;

  clint_tick i_tick (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  // address decode
  assign is_write   = |request.wstrb;
  assign time_sel   = request.addr == clint_pkg::mtime_addr;
  assign cmp_offset = request.addr - clint_pkg::mtimecmp_base;
  // below the base the offset wraps and fails the span check
  assign cmp_sel    = (cmp_offset < clint_pkg::mtimecmp_span) && (cmp_offset[2:0] == 3'b000);
  assign cmp_index  = cmp_offset[3 +: clint_pkg::hart_width];

  // mtime
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
    end else begin
      if (tick) begin
        mtime <= mtime + 64'd1;
      end
      if (request.valid && time_sel && is_write) begin
        mtime <= request.wdata;  // bus write wins over the tick
      end
    end
  end

  // compare registers
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtimecmp <= '{default: '0};
    end else if (request.valid && cmp_sel && is_write) begin
      mtimecmp[cmp_index] <= request.wdata;
    end
  end

  // block reply, writes answer with zero data
  always_ff @(posedge clock) begin
    if (!reset) begin
      reply <= '0;
    end else begin
      reply <= '0;
      if (request.valid && time_sel) begin
        reply.hit <= 1'b1;
        if (!is_write) begin
          reply.rdata <= mtime;
        end
      end
      if (request.valid && cmp_sel) begin
        reply.hit <= 1'b1;
        if (!is_write) begin
          reply.rdata <= mtimecmp[cmp_index];
        end
      end
    end
  end

  // interrupt level per hart
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtip <= '0;
    end else begin
      for (int h = 0; h < clint_pkg::hart_count; h++) begin
        mtip[h] <= mtime >= mtimecmp[h];
      end
    end
  end

  timer_hit_follows_request: assert property (
    @(posedge clock) disable iff (!reset) reply.hit |-> $past(request.valid)
  ) else $error("timer reply without a request");

endmodule

/* verilog/clint_top.sv */
`timescale 1ns/1ps

module clint_top (
  input  logic                    clock,
  input  logic                    reset,
  input  clint_pkg::mem_in_t      request,
  output clint_pkg::mem_out_t     reply,
  output clint_pkg::clint_data_t  mtime,
  output clint_pkg::clint_harts_t msip,
  output clint_pkg::clint_harts_t mtip
);

  clint_pkg::block_resp_t soft_reply;
  clint_pkg::block_resp_t timer_reply;

  // msip registers
  clint_soft i_soft (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .reply   (soft_reply),
    .msip    (msip)
  );

  // mtime and compare registers
  clint_timer i_timer (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .reply   (timer_reply),
    .mtime   (mtime),
    .mtip    (mtip)
  );

  clint_response i_response (
    .clock       (clock),
    .reset       (reset),
    .valid       (request.valid),
    .soft_reply  (soft_reply),
    .timer_reply (timer_reply),
    .reply       (reply)
  );

endmodule
